// ==== all.f ====
+incdir+hdl
+incdir+test
hdl/dvi_rx_pkg.sv
hdl/word_strobe_gen.sv
hdl/tmds_lane.sv
hdl/tmds_decoder.sv
hdl/pixel_assembler.sv
hdl/dvi_rx.sv
test/tb_dvi_rx.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the DVI receiver testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert \
    -f all.f \
    --top-module tb_dvi_rx \
    -Mdir "$OBJ"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$OBJ/Vtb_dvi_rx" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Result: PASSED" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== test/tmds_encoder_model.svh ====
/*
 * Reference TMDS encoder for the testbench. Encodes one byte with the
 * DVI running-disparity rules and maps {c1, c0} to a control token.
 * Included inside the testbench module.
 */
`ifndef TMDS_ENCODER_MODEL_SVH
`define TMDS_ENCODER_MODEL_SVH

// disp carries the lane's running disparity between calls
function automatic dvi_rx_pkg::tmds_word_t tmds_encode(input dvi_rx_pkg::byte_t d,
                                                       inout int disp);
    logic [8:0]             qm;
    int                     n1d;
    int                     n1q;
    int                     n0q;
    dvi_rx_pkg::tmds_word_t w;
    n1d   = $countones(d);
    qm[0] = d[0];
    // first stage: pick the chain that gives fewer transitions
    if (n1d > 4 || (n1d == 4 && d[0] == 1'b0)) begin
        for (int i = 1; i < 8; i++) begin
            qm[i] = ~(qm[i-1] ^ d[i]);
        end
        qm[8] = 1'b0;
    end else begin
        for (int i = 1; i < 8; i++) begin
            qm[i] = qm[i-1] ^ d[i];
        end
        qm[8] = 1'b1;
    end
    n1q = $countones(qm[7:0]);
    n0q = 8 - n1q;
    // second stage: dc balance
    if (disp == 0 || n1q == n0q) begin
        w[9]   = ~qm[8];
        w[8]   = qm[8];
        w[7:0] = qm[8] ? qm[7:0] : ~qm[7:0];
        if (qm[8]) begin
            disp = disp + n1q - n0q;
        end else begin
            disp = disp + n0q - n1q;
        end
    end else if ((disp > 0 && n1q > n0q) || (disp < 0 && n0q > n1q)) begin
        w[9]   = 1'b1;
        w[8]   = qm[8];
        w[7:0] = ~qm[7:0];
        disp   = disp + 2 * int'(qm[8]) + n0q - n1q;
    end else begin
        w[9]   = 1'b0;
        w[8]   = qm[8];
        w[7:0] = qm[7:0];
        disp   = disp + n1q - n0q - 2 * int'(!qm[8]);
    end
    return w;
endfunction

// control token table, indexed by {c1, c0}
function automatic dvi_rx_pkg::tmds_word_t ctrl_token(input logic [1:0] c);
    case (c)
        2'd0:    return `DVI_CTRL_TOKEN_0;
        2'd1:    return `DVI_CTRL_TOKEN_1;
        2'd2:    return `DVI_CTRL_TOKEN_2;
        default: return `DVI_CTRL_TOKEN_3;
    endcase
endfunction

`endif

// ==== test/tb_dvi_rx.sv ====
/*
 * Testbench for the DVI receiver. Serialises encoded blanking and video
 * words on three lanes with random bit delays, waits for lock, then
 * compares the pixel stream against a queue of expected entries.
 */
`include "dvi_rx_macros.svh"

module tb_dvi_rx;

`include "tmds_encoder_model.svh"

localparam int CLK_PERIOD  = 8;
localparam int RST_CYCLES  = 5;
localparam int WB          = `DVI_WORD_BITS;
localparam int LINES       = 4;
localparam int BLANK_WORDS = 12;
localparam int VIDEO_WORDS = 40;
localparam int LINE_WORDS  = BLANK_WORDS + VIDEO_WORDS;
localparam int FRAME_WORDS = LINES * LINE_WORDS;
localparam int LOCK_WORDS  = 10 * (`DVI_SLIP_WAIT + `DVI_LOCK_WORDS + 1);
localparam int TAIL_WORDS  = 40;
localparam int RUN_WORDS   = LOCK_WORDS + FRAME_WORDS + TAIL_WORDS;
localparam int MAX_WORDS   = 512;

logic        clk_i;
logic        rst_n_i;
logic        cal_en_i;
logic [2:0]  tmds_i;
logic [23:0] pixel_o;
logic        de_o;
logic        hsync_o;
logic        vsync_o;
logic        pix_stb_o;
logic        locked_o;

logic [31:0] lcg_state;
int          lane_delay [3];
int          disp [3];
int          edge_cnt;
int          frame_word;
int          sched_cnt;
int          last_stb_cycle;
int          inv_words;
int          plain_words;
int          lock_cycles;
logic [1:0]  last_sync;
bit          frames_req;
bit          frames_done;
bit          synced;
bit          have_stb;

// expected entry {de, hsync, vsync, pixel}
logic [26:0] exp_q [$];

dvi_rx_pkg::tmds_word_t tx_words [3][MAX_WORDS];

dvi_rx DUT (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .cal_en_i(cal_en_i),
    .tmds_i(tmds_i),
    .pixel_o(pixel_o),
    .de_o(de_o),
    .hsync_o(hsync_o),
    .vsync_o(vsync_o),
    .pix_stb_o(pix_stb_o),
    .locked_o(locked_o)
);

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

task automatic stop_failed();
    $display("Result: FAILED");
    $fatal(1);
endtask

task automatic value_error(input string test, input logic [31:0] exp, input logic [31:0] act);
    $display("** Error %s expected %0h actual %0h", test, exp, act);
    stop_failed();
endtask

task automatic run_error(input string what);
    $display("Error: %s", what);
    stop_failed();
endtask

// fills word k of all three lanes and queues what the DUT should output
task automatic produce_word(input int k);
    logic [31:0] r;
    logic [23:0] pix;
    logic [1:0]  sync;
    int          dl;
    if (k >= MAX_WORDS) begin
        run_error("word store overflow");
    end
    if (!frames_req || frames_done) begin
        for (int l = 0; l < 3; l++) begin
            tx_words[l][k] = ctrl_token(2'd0);
            disp[l] = 0;
        end
    end else begin
        if (frame_word % LINE_WORDS < BLANK_WORDS) begin
            // schedule skips 00 first so the frame start differs from calibration
            sync = 2'((sched_cnt + 1) % 4);
            sched_cnt++;
            tx_words[0][k] = ctrl_token(sync);
            tx_words[1][k] = ctrl_token(2'd0);
            tx_words[2][k] = ctrl_token(2'd0);
            for (int l = 0; l < 3; l++) begin
                disp[l] = 0;
            end
            last_sync = sync;
            exp_q.push_back({1'b0, sync[0], sync[1], 24'h0});
        end else begin
            r   = lcg_next();
            pix = r[23:0];
            for (int l = 0; l < 3; l++) begin
                dl = disp[l];
                tx_words[l][k] = tmds_encode(pix[8*l +: 8], dl);
                disp[l] = dl;
            end
            if (tx_words[0][k][9]) begin
                inv_words++;
            end else begin
                plain_words++;
            end
            exp_q.push_back({1'b1, last_sync[0], last_sync[1], pix});
        end
        frame_word++;
        if (frame_word == FRAME_WORDS) begin
            frames_done = 1'b1;
        end
    end
endtask

initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
end

// serialiser sends LSB first with one bit of lead so the boundary lands at slip == delay
always @(posedge clk_i) begin
    int t;
    int n;
    edge_cnt++;
    t = edge_cnt - RST_CYCLES;
    if (t >= 0) begin
        if (t % WB == 0) begin
            produce_word(t / WB);
        end
        for (int l = 0; l < 3; l++) begin
            n = t - 1 - lane_delay[l];
            if (n < 0) begin
                tmds_i[l] <= 1'b0;
            end else begin
                tmds_i[l] <= tx_words[l][n / WB][n % WB];
            end
        end
    end
end

// scoreboard samples mid-cycle
always @(negedge clk_i) begin
    logic [26:0] e;
    string       tname;
    if (!rst_n_i && edge_cnt >= 1) begin
        assert ({pix_stb_o, de_o, hsync_o, vsync_o, locked_o} == 5'b0)
            else value_error("reset", 32'h0,
                             32'({pix_stb_o, de_o, hsync_o, vsync_o, locked_o}));
    end
    if (rst_n_i && pix_stb_o) begin
        if (synced && have_stb) begin
            assert (edge_cnt - last_stb_cycle == WB)
                else value_error("strobe period", WB, edge_cnt - last_stb_cycle);
        end
        have_stb       = 1'b1;
        last_stb_cycle = edge_cnt;
        if (!synced && locked_o && exp_q.size() > 0) begin
            if (exp_q[0][26:24] == {de_o, hsync_o, vsync_o}) begin
                synced = 1'b1;
            end
        end
        if (synced && exp_q.size() > 0) begin
            e     = exp_q.pop_front();
            tname = e[26] ? "video" : "blanking";
            assert (de_o == e[26])
                else value_error({tname, " de"}, 32'(e[26]), 32'(de_o));
            assert (hsync_o == e[25])
                else value_error({tname, " hsync"}, 32'(e[25]), 32'(hsync_o));
            assert (vsync_o == e[24])
                else value_error({tname, " vsync"}, 32'(e[24]), 32'(vsync_o));
            assert (pixel_o == e[23:0])
                else value_error({tname, " pixel"}, 32'(e[23:0]), 32'(pixel_o));
        end
    end
end

assert property (@(posedge clk_i) disable iff (!rst_n_i) locked_o |=> locked_o)
    else run_error("locked_o fell after lock");

initial begin
    #(RUN_WORDS * WB * CLK_PERIOD * 2);
    run_error("watchdog timeout, the output stream did not finish");
end

initial begin
    logic [31:0] r;
    rst_n_i   = 1'b0;
    cal_en_i  = 1'b1;
    tmds_i    = 3'b000;
    lcg_state = 32'hed99;
    edge_cnt  = 0;
    last_sync = 2'd0;
    for (int l = 0; l < 3; l++) begin
        r = lcg_next();
        lane_delay[l] = int'(r[31:16] % 16'd10);
        disp[l] = 0;
    end
    repeat (RST_CYCLES) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // calibration on token 0 until all lanes lock
    lock_cycles = 0;
    while (!locked_o) begin
        @(negedge clk_i);
        lock_cycles++;
        assert (lock_cycles <= LOCK_WORDS * WB)
            else run_error("locked_o did not rise within the calibration bound");
    end
    @(posedge clk_i);
    cal_en_i <= 1'b0;
    @(negedge clk_i);
    frames_req = 1'b1;

    while (!(frames_done && synced && exp_q.size() == 0)) begin
        @(negedge clk_i);
    end
    // a few more pixels for the strobe period check
    repeat (3 * WB) @(negedge clk_i);

    if (inv_words > 0 && plain_words > 0) begin
        $display("Result: PASSED");
        $finish;
    end else begin
        run_error("video did not use both inversion polarities");
    end
end

endmodule

// ==== hdl/dvi_rx.sv ====
/*
 * DVI receiver top. One bit clock at ten times the pixel rate drives
 * the word strobe, three lane/decoder pairs (blue, green, red on
 * tmds_i[0..2]) and the pixel assembler. Qualify the pixel stream
 * with locked_o.
 */
module dvi_rx (
    input  logic       clk_i,
    input  logic       rst_n_i,

    input  logic       cal_en_i,
    input  logic [2:0] tmds_i,

    output logic [23:0] pixel_o,
    output logic        de_o,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        pix_stb_o,
    output logic        locked_o
);

logic word_stb;

dvi_rx_pkg::tmds_word_t [2:0] lane_word;
dvi_rx_pkg::byte_t [2:0]      lane_data;

logic [2:0] lane_locked;
logic [2:0] lane_de;
logic [2:0] lane_c0;
logic [2:0] lane_c1;
logic [2:0] dec_valid;

word_strobe_gen u_word_strobe_gen (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .word_stb_o(word_stb)
);

// lane 0 blue, 1 green, 2 red
for (genvar i = 0; i < 3; i++) begin : g_lane
    tmds_lane u_lane (
        .clk_i(clk_i),
        .rst_n_i(rst_n_i),
        .cal_en_i(cal_en_i),
        .word_stb_i(word_stb),
        .ser_i(tmds_i[i]),
        .word_o(lane_word[i]),
        .locked_o(lane_locked[i])
    );

    tmds_decoder u_decoder (
        .clk_i(clk_i),
        .rst_n_i(rst_n_i),
        .word_stb_i(word_stb),
        .word_i(lane_word[i]),
        .data_o(lane_data[i]),
        .de_o(lane_de[i]),
        .c0_o(lane_c0[i]),
        .c1_o(lane_c1[i]),
        .dec_valid_o(dec_valid[i])
    );
end

pixel_assembler u_pixel_assembler (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .dec_valid_i(dec_valid[0]),
    .blue_i(lane_data[0]),
    .green_i(lane_data[1]),
    .red_i(lane_data[2]),
    .de_i(lane_de[0]),
    .c0_i(lane_c0[0]),
    .c1_i(lane_c1[0]),
    .lane_locked_i(lane_locked),
    .pixel_o(pixel_o),
    .de_o(de_o),
    .hsync_o(hsync_o),
    .vsync_o(vsync_o),
    .pix_stb_o(pix_stb_o),
    .locked_o(locked_o)
);

endmodule

// ==== hdl/pixel_assembler.sv ====
/*
 * Merges the three decoded lanes into one pixel stream. Samples all
 * lanes on the blue decoder's valid pulse; sync and de come from blue.
 * The overall lock is the AND of the three lane locks.
 */
module pixel_assembler (
    input  logic clk_i,
    input  logic rst_n_i,

    input  logic              dec_valid_i,
    input  dvi_rx_pkg::byte_t blue_i,
    input  dvi_rx_pkg::byte_t green_i,
    input  dvi_rx_pkg::byte_t red_i,
    input  logic              de_i,
    input  logic              c0_i,
    input  logic              c1_i,
    input  logic [2:0]        lane_locked_i,

    output logic [23:0] pixel_o,
    output logic        de_o,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        pix_stb_o,
    output logic        locked_o
);

always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
        pix_stb_o <= 1'b0;
        de_o      <= 1'b0;
        hsync_o   <= 1'b0;
        vsync_o   <= 1'b0;
        locked_o  <= 1'b0;
    end else begin
        pix_stb_o <= dec_valid_i;
        locked_o  <= &lane_locked_i;
        if (dec_valid_i) begin
            de_o    <= de_i;
            // c0 carries hsync, c1 vsync
            hsync_o <= c0_i;
            vsync_o <= c1_i;
        end
    end
end

// red in the upper byte
always_ff @(posedge clk_i) begin
    if (dec_valid_i) begin
        pixel_o <= {red_i, green_i, blue_i};
    end
end

assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pix_stb_o == $past(dec_valid_i));

// no lane drops lock short of a reset
assert property (@(posedge clk_i) disable iff (!rst_n_i)
    locked_o |=> locked_o);

endmodule

// ==== hdl/tmds_decoder.sv ====
/*
 * TMDS 10b-to-8b decoder for one channel. Registers the lane word in the
 * cycle after the strobe: control tokens give de low and {c1, c0},
 * other words give de high and the recovered byte.
 */
`include "dvi_rx_macros.svh"

module tmds_decoder (
    input  logic clk_i,
    input  logic rst_n_i,

    input  logic                   word_stb_i,
    input  dvi_rx_pkg::tmds_word_t word_i,

    output dvi_rx_pkg::byte_t data_o,
    output logic              de_o,
    output logic              c0_o,
    output logic              c1_o,
    output logic              dec_valid_o
);

logic       word_vld;
logic       is_token;
logic [1:0] tok_idx;

dvi_rx_pkg::byte_t dec_byte;

function automatic dvi_rx_pkg::byte_t tmds_decode(input dvi_rx_pkg::tmds_word_t w);
    dvi_rx_pkg::byte_t d;
    dvi_rx_pkg::byte_t q;
    // bit 9 marks an inverted data field
    d    = w[9] ? ~w[7:0] : w[7:0];
    q[0] = d[0];
    // bit 8 set means the encoder used the xor chain
    for (int i = 1; i < 8; i++) begin
        q[i] = w[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
    end
    return q;
endfunction

always_comb begin
    is_token = 1'b1;
    tok_idx  = 2'd0;
    case (word_i)
        `DVI_CTRL_TOKEN_0: tok_idx = 2'd0;
        `DVI_CTRL_TOKEN_1: tok_idx = 2'd1;
        `DVI_CTRL_TOKEN_2: tok_idx = 2'd2;
        `DVI_CTRL_TOKEN_3: tok_idx = 2'd3;
        default:           is_token = 1'b0;
    endcase
    dec_byte = tmds_decode(word_i);
end

// lane word is valid one cycle after the strobe
always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
        word_vld    <= 1'b0;
        dec_valid_o <= 1'b0;
        de_o        <= 1'b0;
        c0_o        <= 1'b0;
        c1_o        <= 1'b0;
    end else begin
        word_vld    <= word_stb_i;
        dec_valid_o <= word_vld;
        if (word_vld) begin
            de_o <= !is_token;
            if (is_token) begin
                {c1_o, c0_o} <= tok_idx;
            end
        end
    end
end

always_ff @(posedge clk_i) begin
    if (word_vld) begin
        data_o <= is_token ? '0 : dec_byte;
    end
end

// decoded word follows the lane's captured word by one cycle
assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dec_valid_o == $past(word_stb_i, 2));

endmodule

// ==== hdl/tmds_lane.sv ====
/*
 * One TMDS channel: deserialises the bit stream, captures a word at each
 * strobe from a selectable bit offset, and slips that offset during
 * calibration until a run of control tokens proves the word boundary.
 */
`include "dvi_rx_macros.svh"

module tmds_lane (
    input  logic clk_i,
    input  logic rst_n_i,

    input  logic cal_en_i,
    input  logic word_stb_i,
    input  logic ser_i,

    output dvi_rx_pkg::tmds_word_t word_o,
    output logic                   locked_o
);

localparam int SR_W  = 2 * `DVI_WORD_BITS;
localparam int TOK_W = $clog2(`DVI_LOCK_WORDS + 1);
localparam int WAIT_W = $clog2(`DVI_SLIP_WAIT + 1);

localparam logic [TOK_W-1:0]  TOK_LAST  = TOK_W'(`DVI_LOCK_WORDS - 1);
localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(`DVI_SLIP_WAIT - 1);
localparam dvi_rx_pkg::slip_t SLIP_LAST = dvi_rx_pkg::slip_t'(`DVI_WORD_BITS - 1);

logic [SR_W-1:0]   sr;
logic              cap_vld;
logic              is_token;
logic [TOK_W-1:0]  tok_cnt;
logic [WAIT_W-1:0] wait_cnt;

dvi_rx_pkg::slip_t        slip;
dvi_rx_pkg::align_state_e state;

// newest bit enters at the top, so a window reads LSB first upward
always_ff @(posedge clk_i) begin
    sr <= {ser_i, sr[SR_W-1:1]};
    if (word_stb_i) begin
        word_o <= sr[slip +: `DVI_WORD_BITS];
    end
end

always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
        cap_vld <= 1'b0;
    end else begin
        cap_vld <= word_stb_i;
    end
end

assign is_token = (word_o == `DVI_CTRL_TOKEN_0) || (word_o == `DVI_CTRL_TOKEN_1) ||
                  (word_o == `DVI_CTRL_TOKEN_2) || (word_o == `DVI_CTRL_TOKEN_3);

// aligner, judged once per captured word
always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
        state    <= dvi_rx_pkg::ALIGN_HUNT;
        slip     <= '0;
        tok_cnt  <= '0;
        wait_cnt <= '0;
    end else if (cap_vld) begin
        case (state)
            dvi_rx_pkg::ALIGN_HUNT: begin
                if (is_token) begin
                    tok_cnt <= tok_cnt + 1'b1;
                    if (tok_cnt == TOK_LAST) begin
                        state <= dvi_rx_pkg::ALIGN_LOCKED;
                    end
                end else begin
                    tok_cnt <= '0;
                    if (cal_en_i) begin
                        slip     <= (slip == SLIP_LAST) ? '0 : slip + 1'b1;
                        wait_cnt <= '0;
                        state    <= dvi_rx_pkg::ALIGN_WAIT;
                    end
                end
            end
            dvi_rx_pkg::ALIGN_WAIT: begin
                // skip words captured across the slip
                wait_cnt <= wait_cnt + 1'b1;
                if (wait_cnt == WAIT_LAST) begin
                    state <= dvi_rx_pkg::ALIGN_HUNT;
                end
            end
            default: begin
                state <= dvi_rx_pkg::ALIGN_LOCKED;
            end
        endcase
    end
end

assign locked_o = (state == dvi_rx_pkg::ALIGN_LOCKED);

assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slip <= SLIP_LAST);

// once locked the word boundary is frozen
assert property (@(posedge clk_i) disable iff (!rst_n_i)
    locked_o |=> $stable(slip));

endmodule

// ==== hdl/word_strobe_gen.sv ====
/*
 * Word strobe for all three TMDS lanes. Divides the bit clock by the
 * word length and emits a one-cycle pulse, the first one in the first
 * cycle after reset is released.
 */
`include "dvi_rx_macros.svh"

module word_strobe_gen (
    input  logic clk_i,
    input  logic rst_n_i,

    output logic word_stb_o
);

localparam int CNT_W = $clog2(`DVI_WORD_BITS);
localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`DVI_WORD_BITS - 1);

logic [CNT_W-1:0] cnt;

always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
        cnt        <= '0;
        word_stb_o <= 1'b0;
    end else begin
        // pulse on the cycle after the counter sits at zero
        word_stb_o <= (cnt == '0);
        if (cnt == CNT_LAST) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end
end

// a strobe is always followed by a quiet cycle
assert property (@(posedge clk_i) disable iff (!rst_n_i)
    word_stb_o |=> !word_stb_o);

endmodule

// ==== hdl/dvi_rx_pkg.sv ====
/*
 * Types shared by the DVI receiver modules and the testbench.
 * Referenced by scoped name, so compile it before the modules.
 */
`include "dvi_rx_macros.svh"

package dvi_rx_pkg;

    // one 10-bit TMDS code word, bit 0 is the first bit on the wire
    typedef logic [`DVI_WORD_BITS-1:0] tmds_word_t;

    // one colour component
    typedef logic [7:0] byte_t;

    // bit-slip offset into the lane shift register, 0 to 9
    typedef logic [3:0] slip_t;

    // word aligner of each lane
    typedef enum logic [1:0] {
        ALIGN_HUNT,
        ALIGN_WAIT,
        ALIGN_LOCKED
    } align_state_e;

endpackage

// ==== hdl/dvi_rx_macros.svh ====
/*
 * Shared constants of the DVI receiver: TMDS word length, alignment
 * counts and the four control tokens, sent LSB first on the wire.
 * Included by the package and by every module that needs them.
 */
`ifndef DVI_RX_MACROS_SVH
`define DVI_RX_MACROS_SVH

`define DVI_WORD_BITS   10
`define DVI_LOCK_WORDS  8
`define DVI_SLIP_WAIT   2

// control tokens indexed by {c1, c0}
`define DVI_CTRL_TOKEN_0  10'b1101010100
`define DVI_CTRL_TOKEN_1  10'b0010101011
`define DVI_CTRL_TOKEN_2  10'b0101010100
`define DVI_CTRL_TOKEN_3  10'b1010101011

`endif
